//--- logic/ram_pkg.sv
package ram_pkg;

    // one stored word, as seen on the bus
    localparam int DATA_WIDTH = 32;

    // byte lanes per word, one select bit each
    localparam int BYTE_COUNT = 4;

    // width of one lane
    localparam int BYTE_WIDTH = DATA_WIDTH / BYTE_COUNT;

    // full data word
    typedef logic [DATA_WIDTH-1:0] word_t;

    // per-lane write enables
    // bit i covers word bits [8*i+7:8*i]
    typedef logic [BYTE_COUNT-1:0] byte_sel_t;

    // post-reset sweep FSM
    // clear_sweep writes zeros, clear_done hands the banks to the bus
    typedef enum logic [0:0] {
        clear_sweep,
        clear_done
    } clear_state_t;

endpackage

//--- logic/bank_port_if.sv
interface bank_port_if
    import ram_pkg::*;
#(
    parameter int BANK_DEPTH = 64
) ();

    // address width of one bank
    localparam int ADDR_WIDTH = $clog2(BANK_DEPTH);

    // access strobe, read or write
    logic                  en;
    // byte lanes to write, all zero on a read
    byte_sel_t             we;
    // word address inside the bank
    logic [ADDR_WIDTH-1:0] addr;
    // write data
    word_t                 wdata;
    // registered read word, one cycle after en
    word_t                 rdata;

    // controller side
    modport ctrl (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    // storage side
    modport mem (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

//--- logic/ram_bank.sv
module ram_bank
    import ram_pkg::*;
#(
    parameter int BANK_DEPTH = 64
) (
    input logic        clk,
    bank_port_if.mem   port
);

    localparam int ADDR_WIDTH = $clog2(BANK_DEPTH);

    // storage kept as byte lanes so each lane writes on its own
    logic [BYTE_COUNT-1:0][BYTE_WIDTH-1:0] mem [BANK_DEPTH];

    // one address serves both the read and the write
    logic [ADDR_WIDTH-1:0] addr;

    // lane split of the incoming write word
    logic [BYTE_COUNT-1:0][BYTE_WIDTH-1:0] wdata_lanes;

    assign addr        = port.addr;
    assign wdata_lanes = port.wdata;

    // byte-masked write
    // lanes with we low keep their contents
    always_ff @(posedge clk) begin
        if (port.en) begin
            for (int j = 0; j < BYTE_COUNT; j++) begin
                if (port.we[j]) begin
                    mem[addr][j] <= wdata_lanes[j];
                end
            end
        end
    end

    // registered read with one cycle of latency
    // nonblocking update means a same-cycle write returns the old word
    always_ff @(posedge clk) begin
        if (port.en) begin
            port.rdata <= mem[addr];
        end
    end

endmodule

//--- logic/bank_clear.sv
module bank_clear
    import ram_pkg::*;
#(
    parameter int BANK_DEPTH = 64,
    localparam int ADDR_WIDTH = $clog2(BANK_DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  clearing,
    output logic [ADDR_WIDTH-1:0] clear_addr,
    output logic                  ready
);

    // last word of a bank
    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(BANK_DEPTH - 1);

    clear_state_t          state;
    clear_state_t          state_next;
    logic [ADDR_WIDTH-1:0] count;
    logic [ADDR_WIDTH-1:0] count_next;

    // next state and counter
    always_comb begin
        state_next = state;
        count_next = count;
        case (state)
            clear_sweep: begin
                // one word per cycle, both banks at once
                count_next = count + 1'b1;
                // last word goes out on this edge
                if (count == LAST_ADDR) begin
                    state_next = clear_done;
                end
            end
            clear_done: begin
                // sweep finished, hold until next reset
                count_next = count;
            end
            default: begin
                state_next = clear_sweep;
                count_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= clear_sweep;
            count <= '0;
        end else begin
            state <= state_next;
            count <= count_next;
        end
    end

    // decoded straight from the state
    // clearing is high through reset, ready after the last zero lands
    assign clearing   = (state == clear_sweep);
    assign ready      = (state == clear_done);
    assign clear_addr = count;

endmodule

//--- logic/wb_bank_front.sv
module wb_bank_front
    import ram_pkg::*;
#(
    parameter int BANK_DEPTH = 64,
    localparam int BANK_AW = $clog2(BANK_DEPTH)
) (
    input  logic               clk,
    input  logic               rst,

    // Wishbone classic slave
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  byte_sel_t          wb_sel,
    input  logic [BANK_AW:0]   wb_adr,
    input  word_t              wb_dat_w,
    output word_t              wb_dat_r,
    output logic               wb_ack,

    // from the post-reset sweep
    input  logic               clearing,
    input  logic [BANK_AW-1:0] clear_addr,
    input  logic               ready,

    // the two banks
    bank_port_if.ctrl          lo,
    bank_port_if.ctrl          hi
);

    // bus request as the master sees it
    logic req;
    // request not yet answered and storage open for use
    logic access;
    // top address bit picks the bank
    logic sel_hi;
    logic [BANK_AW-1:0] bank_addr;

    // per-bank strobes
    logic lo_en;
    logic hi_en;

    // shared drive for both banks
    logic [BANK_AW-1:0] port_addr;
    word_t              port_wdata;
    byte_sel_t          port_we;

    // acknowledge and the bank the answer comes from
    logic ack_q;
    logic sel_hi_q;

    assign req       = wb_cyc & wb_stb;
    assign sel_hi    = wb_adr[BANK_AW];
    assign bank_addr = wb_adr[BANK_AW-1:0];

    // in the ack cycle the master still holds its request
    // so that cycle must not start another access
    // while ready is low the request just waits
    assign access = req & ~ack_q & ready & ~clearing;

    // sweep owns both banks, otherwise only the addressed one runs
    assign lo_en = clearing | (access & ~sel_hi);
    assign hi_en = clearing | (access & sel_hi);

    // sweep writes zeros to every lane
    always_comb begin
        if (clearing) begin
            port_addr  = clear_addr;
            port_wdata = '0;
            port_we    = '1;
        end else begin
            port_addr  = bank_addr;
            port_wdata = wb_dat_w;
            // reads leave all lanes alone
            port_we    = wb_we ? wb_sel : '0;
        end
    end

    // low bank
    assign lo.en    = lo_en;
    assign lo.we    = lo_en ? port_we : '0;
    assign lo.addr  = port_addr;
    assign lo.wdata = port_wdata;

    // high bank
    assign hi.en    = hi_en;
    assign hi.we    = hi_en ? port_we : '0;
    assign hi.addr  = port_addr;
    assign hi.wdata = port_wdata;

    // one access in flight at most
    // ack follows the request by exactly one edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q    <= 1'b0;
            sel_hi_q <= 1'b0;
        end else begin
            ack_q <= access;
            // remember where the read word will come from
            if (access) begin
                sel_hi_q <= sel_hi;
            end
        end
    end

    assign wb_ack = ack_q;

    // bank read data is registered, so it lines up with ack
    assign wb_dat_r = sel_hi_q ? hi.rdata : lo.rdata;

endmodule

//--- logic/banked_ram_top.sv
module banked_ram_top
    import ram_pkg::*;
#(
    parameter int BANK_DEPTH = 64,
    localparam int BANK_AW = $clog2(BANK_DEPTH)
) (
    input  logic             clk,
    input  logic             rst,

    // Wishbone classic slave, word addressed
    // top bit of wb_adr picks the bank
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  byte_sel_t        wb_sel,
    input  logic [BANK_AW:0] wb_adr,
    input  word_t            wb_dat_w,
    output word_t            wb_dat_r,
    output logic             wb_ack,

    // high once both banks hold zeros
    output logic             ready
);

    // sweep to front end
    logic               clearing;
    logic [BANK_AW-1:0] clear_addr;

    // one access bundle per bank
    bank_port_if #(
        .BANK_DEPTH(BANK_DEPTH)
    ) bank_lo ();

    bank_port_if #(
        .BANK_DEPTH(BANK_DEPTH)
    ) bank_hi ();

    // lower half of the word space
    ram_bank #(
        .BANK_DEPTH(BANK_DEPTH)
    ) u_bank_lo (
        .clk  (clk),
        .port (bank_lo.mem)
    );

    // upper half
    ram_bank #(
        .BANK_DEPTH(BANK_DEPTH)
    ) u_bank_hi (
        .clk  (clk),
        .port (bank_hi.mem)
    );

    // zero fill after reset, both banks in step
    bank_clear #(
        .BANK_DEPTH(BANK_DEPTH)
    ) u_clear (
        .clk        (clk),
        .rst        (rst),
        .clearing   (clearing),
        .clear_addr (clear_addr),
        .ready      (ready)
    );

    // bus decode, sweep mux and read-data select
    wb_bank_front #(
        .BANK_DEPTH(BANK_DEPTH)
    ) u_front (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_sel     (wb_sel),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .clearing   (clearing),
        .clear_addr (clear_addr),
        .ready      (ready),
        .lo         (bank_lo.ctrl),
        .hi         (bank_hi.ctrl)
    );

endmodule

//--- tests/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    // free running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset released on a falling edge, RESET_CYCLES periods after start
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tests/tb_banked_ram.sv
module tb_banked_ram
    import ram_pkg::*;
();

    localparam int BANK_DEPTH   = 64;
    localparam int ADR_WIDTH    = $clog2(BANK_DEPTH) + 1;
    localparam int WORD_COUNT   = 2 * BANK_DEPTH;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_COUNT = 200;
    // accesses per test in run order
    localparam int ACCESS_COUNT = WORD_COUNT + 16 + 30 + 7 + 5 + RANDOM_COUNT;
    // four cycles per access at most plus sweep, reset and slack
    localparam int WATCHDOG_CYCLES = ACCESS_COUNT * 4 + BANK_DEPTH + RESET_CYCLES + 200;

    logic                 clk;
    logic                 rst;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    byte_sel_t            wb_sel;
    logic [ADR_WIDTH-1:0] wb_adr;
    word_t                wb_dat_w;
    word_t                wb_dat_r;
    logic                 wb_ack;
    logic                 ready;

    // expected contents over both banks
    word_t model [WORD_COUNT];

    integer seed;

    tb_clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk (clk),
        .rst (rst)
    );

    banked_ram_top #(
        .BANK_DEPTH (BANK_DEPTH)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ready    (ready)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected 0x%h, actual 0x%h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    // selected byte lanes take the new data and the others keep the old value
    function automatic void model_write(input logic [ADR_WIDTH-1:0] addr,
                                        input byte_sel_t sel, input word_t data);
        for (int i = 0; i < BYTE_COUNT; i++) begin
            if (sel[i]) begin
                model[addr][8*i +: 8] = data[8*i +: 8];
            end
        end
    endfunction

    // data tied to every address bit
    function automatic word_t addr_pattern(input logic [ADR_WIDTH-1:0] a);
        return {8'hc3, 1'b0, a, 1'b1, ~a, 8'h5a};
    endfunction

    // ack must come at the first falling edge after the request
    task automatic wait_for_ack(input string name, output word_t data);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (wb_ack !== 1'b1);
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        check_value({name, " ack latency"}, 32'd1, waited);
    endtask

    task automatic wb_write(input string name, input logic [ADR_WIDTH-1:0] addr,
                            input byte_sel_t sel, input word_t data);
        word_t ignored;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_sel   = sel;
        wb_dat_w = data;
        wait_for_ack(name, ignored);
        model_write(addr, sel, data);
    endtask

    task automatic wb_read(input string name, input logic [ADR_WIDTH-1:0] addr,
                           output word_t data);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        wb_sel = '1;
        wait_for_ack(name, data);
    endtask

    task automatic read_and_compare(input string name, input logic [ADR_WIDTH-1:0] addr);
        word_t data;
        wb_read(name, addr, data);
        check_value(name, model[addr], data);
    endtask

    task automatic test_clear_after_reset();
        int cycles;
        cycles = 0;
        // inside reset
        @(negedge clk);
        check_value("reset ack", 32'd0, wb_ack);
        check_value("reset ready", 32'd0, ready);
        wait (rst === 1'b0);
        // write held through the whole sweep must never land
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_sel   = '1;
        wb_adr   = '0;
        wb_dat_w = 32'hffff_ffff;
        do begin
            @(negedge clk);
            cycles++;
            check_value("ack during sweep", 32'd0, wb_ack);
        end while (ready !== 1'b1);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        check_value("sweep length", BANK_DEPTH, cycles);
        for (int a = 0; a < WORD_COUNT; a++) begin
            read_and_compare($sformatf("cleared word %0d", a), a);
        end
    endtask

    task automatic test_full_word();
        logic [ADR_WIDTH-1:0] addrs [8] = '{0, 1, 37, 63, 64, 65, 100, 127};
        for (int i = 0; i < 8; i++) begin
            wb_write("full word write", addrs[i], 4'b1111, addr_pattern(addrs[i]));
        end
        for (int i = 0; i < 8; i++) begin
            read_and_compare($sformatf("full word %0d", addrs[i]), addrs[i]);
        end
    endtask

    task automatic test_byte_mask();
        logic [ADR_WIDTH-1:0] addrs [2] = '{5, 70};
        byte_sel_t masks [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                 4'b0101, 4'b1010, 4'b0110};
        word_t data;
        for (int i = 0; i < 2; i++) begin
            wb_write("byte mask base", addrs[i], 4'b1111, 32'h1122_3344);
            for (int k = 0; k < 7; k++) begin
                data = 32'ha0b0_c0d0 + k * 32'h0101_0101;
                wb_write("byte mask write", addrs[i], masks[k], data);
                read_and_compare($sformatf("byte mask %0d sel %b", addrs[i], masks[k]),
                                 addrs[i]);
            end
        end
    endtask

    task automatic test_bank_independence();
        logic [ADR_WIDTH-1:0] lo_addr;
        logic [ADR_WIDTH-1:0] hi_addr;
        word_t data;
        lo_addr = 10;
        hi_addr = 10 + BANK_DEPTH;
        // same bank address in the other bank
        wb_write("bank lo write", lo_addr, 4'b1111, 32'h0000_aaaa);
        wb_write("bank hi write", hi_addr, 4'b1111, 32'h5555_0000);
        wb_read("bank lo read", lo_addr, data);
        check_value("bank lo read", 32'h0000_aaaa, data);
        wb_read("bank hi read", hi_addr, data);
        check_value("bank hi read", 32'h5555_0000, data);
        // rewrite lo while hi must stay
        wb_write("bank lo rewrite", lo_addr, 4'b1111, 32'h1234_5678);
        wb_read("bank hi after lo write", hi_addr, data);
        check_value("bank hi after lo write", 32'h5555_0000, data);
        wb_read("bank lo after rewrite", lo_addr, data);
        check_value("bank lo after rewrite", 32'h1234_5678, data);
    endtask

    task automatic test_ack_protocol();
        logic [ADR_WIDTH-1:0] addr;
        word_t data;
        addr = 67;
        wb_write("protocol write", addr, 4'b1111, 32'h5eed_0043);
        // held read gets an ack every other cycle
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        for (int k = 1; k <= 4; k++) begin
            @(negedge clk);
            check_value($sformatf("held ack %0d", k), k % 2, wb_ack);
            if (wb_ack === 1'b1) begin
                check_value($sformatf("held data %0d", k), 32'h5eed_0043, wb_dat_r);
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge clk);
        check_value("ack after drop", 32'd0, wb_ack);
        // single ack for a single request
        wb_read("protocol read", addr, data);
        check_value("protocol read", model[addr], data);
        @(negedge clk);
        check_value("ack once", 32'd0, wb_ack);
    endtask

    task automatic test_random_traffic();
        logic [31:0]          r;
        logic [ADR_WIDTH-1:0] addr;
        word_t                data;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            r    = $random(seed);
            data = $random(seed);
            addr = r[ADR_WIDTH-1:0];
            if (r[8]) begin
                wb_write("random write", addr, r[15:12], data);
            end else begin
                read_and_compare($sformatf("random read %0d at %0d", i, addr), addr);
            end
        end
    endtask

    // ends a run stuck on a missing acknowledge
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: timed out waiting for an acknowledge after %0d cycles",
                 WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_sel   = '0;
        wb_adr   = '0;
        wb_dat_w = '0;
        seed     = 32'h2131;
        for (int a = 0; a < WORD_COUNT; a++) begin
            model[a] = '0;
        end
        test_clear_after_reset();
        test_full_word();
        test_byte_mask();
        test_bank_independence();
        test_ack_protocol();
        test_random_traffic();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- build.f
logic/ram_pkg.sv
logic/bank_port_if.sv
logic/ram_bank.sv
logic/bank_clear.sv
logic/wb_bank_front.sv
logic/banked_ram_top.sv
tests/tb_clock_gen.sv
tests/tb_banked_ram.sv

//--- Bender.yml
package:
  name: banked_ram

sources:
  - logic/ram_pkg.sv
  - logic/bank_port_if.sv
  - logic/ram_bank.sv
  - logic/bank_clear.sv
  - logic/wb_bank_front.sv
  - logic/banked_ram_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_banked_ram.sv
